//--- filelist.f
+incdir+bench
source/daq_line_pkg.sv
source/daq_frame_pkg.sv
source/frame_sequencer.sv
source/crc32_word.sv
source/line_word_out.sv
source/daq_frame_tx.sv
bench/tb_daq_frame_tx.sv

//--- Bender.yml
package:
  name: daq_frame_tx

sources:
  - files:
      - source/daq_line_pkg.sv
      - source/daq_frame_pkg.sv
      - source/frame_sequencer.sv
      - source/crc32_word.sv
      - source/line_word_out.sv
      - source/daq_frame_tx.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_daq_frame_tx.sv

//--- bench/tb_frame_ref.svh
`ifndef TB_FRAME_REF_SVH
`define TB_FRAME_REF_SVH

// Next state of the stimulus LCG, modulo 2^32
function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1103515245 + 32'd12345;
endfunction

// One octet into the reflected Ethernet CRC, LSB first
function automatic logic [31:0] crc_octet(input logic [31:0] crc, input logic [7:0] b);
	logic [31:0] c;
	c = crc;
	for (int i = 0; i < 8; i++)
	begin
		if (c[0] ^ b[i])
			c = (c >> 1) ^ 32'hEDB8_8320;
		else
			c = c >> 1;
	end
	return c;
endfunction

// FCS over the first n words of pkt_data, low octet of each word first
function automatic logic [31:0] ref_fcs(input int n);
	logic [31:0] c;
	c = 32'hFFFF_FFFF;
	for (int i = 0; i < n; i++)
	begin
		c = crc_octet(c, pkt_data[i][7:0]);
		c = crc_octet(c, pkt_data[i][15:8]);
	end
	return ~c;
endfunction

// Expected line words of one packet, entries are {K-flags, word}
function automatic void queue_frame(input int n);
	logic [31:0] fcs;
	fcs = ref_fcs(n);
	exp_q.push_back({2'b01, 16'h55FB}); // SOP
	for (int i = 0; i < PREAMBLE_WORDS; i++)
		exp_q.push_back({2'b00, 16'h5555});
	exp_q.push_back({2'b00, 16'hD555}); // SOF
	for (int i = 0; i < n; i++)
		exp_q.push_back({2'b00, pkt_data[i]});
	exp_q.push_back({2'b00, fcs[15:0]}); // Low half goes first
	exp_q.push_back({2'b00, fcs[31:16]});
	exp_q.push_back({2'b11, 16'hF7FD}); // EOP
	exp_q.push_back({2'b11, 16'hF7F7}); // EXT
endfunction

`endif

//--- bench/tb_daq_frame_tx.sv
`default_nettype none

module tb_daq_frame_tx;

	localparam int IPG_WORDS      = 4;
	localparam int PREAMBLE_WORDS = 2;
	localparam int PKT_LEN_RESET  = 800;
	localparam int DRIVE_DLY      = 10;
	localparam int ACK_LIMIT      = IPG_WORDS + PREAMBLE_WORDS + 16;
	localparam int DRAIN_LIMIT    = 200;
	localparam int N_RANDOM       = 24;
	localparam logic [17:0] SOP_ENTRY = {2'b01, 16'h55FB};
	localparam logic [17:0] EXT_ENTRY = {2'b11, 16'hF7F7};

	logic        usr_clk_wordwise;
	logic        arst;
	logic [15:0] txd_i;
	logic        txd_vld_i;
	logic        tx_ack_o;
	logic [15:0] tx_data_o;
	logic [1:0]  tx_charisk_o;
	logic [9:0]  pkt_len_o;

	logic [15:0] pkt_data [0:63];
	logic [17:0] exp_q [$];      // Expected {K-flags, word} in line order
	int          len_q [$];      // Data word count per queued packet
	logic [31:0] lcg_state;
	int          mismatch_cnt;
	int          fail_cnt;
	bit          aborted;
	logic [17:0] exp_entry;
	int          exp_len;
	int          idle_run;
	int          word_idx;
	bit          in_pkt;
	bit          seen_ext;

	`include "tb_frame_ref.svh"

	daq_frame_tx #(
		.IPG_WORDS      (IPG_WORDS),
		.PREAMBLE_WORDS (PREAMBLE_WORDS),
		.PKT_LEN_RESET  (PKT_LEN_RESET)
	)
	dut
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_i            (txd_i),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.tx_data_o        (tx_data_o),
		.tx_charisk_o     (tx_charisk_o),
		.pkt_len_o        (pkt_len_o)
	);

	initial usr_clk_wordwise = 1'b0;
	always #50 usr_clk_wordwise = ~usr_clk_wordwise;

	task automatic next_cycle();
		@(posedge usr_clk_wordwise);
		#DRIVE_DLY;
	endtask

	task automatic fill_random(input int n);
		for (int i = 0; i < n; i++)
		begin
			lcg_state = lcg_next(lcg_state);
			pkt_data[i] = lcg_state[31:16];
		end
	endtask

	task automatic check_reset_state();
		assert (tx_ack_o == 1'b0)
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: acknowledge high with no request", $time);
		end
		assert (tx_data_o == 16'h50BC && tx_charisk_o == 2'b01)
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: line shows %h/%b instead of idle", $time, tx_data_o,
				tx_charisk_o);
		end
		assert (pkt_len_o == PKT_LEN_RESET[9:0])
		else
		begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: packet length %0d after reset", $time, pkt_len_o);
		end
	endtask

	////////////////////
	// Packet source
	////////////////////

	task automatic send_packet(input int n, input bit check_latency);
		int waited;
		waited = 0;
		queue_frame(n);
		len_q.push_back(n);
		txd_vld_i = 1'b1;
		do
		begin
			next_cycle();
			waited++;
		end
		while (!tx_ack_o && waited < ACK_LIMIT);
		if (!tx_ack_o)
		begin
			fail_cnt++;
			$display("Timeout at %0t: no acknowledge within %0d cycles of the request", $time,
				ACK_LIMIT);
			txd_vld_i = 1'b0;
			aborted   = 1'b1;
			return;
		end
		if (check_latency)
		begin
			assert (waited == 2 + PREAMBLE_WORDS)
			else
			begin
				mismatch_cnt++;
				$display("MISMATCH at %0t: acknowledge after %0d cycles, expected %0d", $time,
					waited, 2 + PREAMBLE_WORDS);
			end
		end
		for (int i = 0; i < n; i++)
		begin
			next_cycle();
			txd_i = pkt_data[i];
			if (i == 0)
			begin
				assert (!tx_ack_o)
				else
				begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: acknowledge longer than one cycle", $time);
				end
			end
		end
		next_cycle();
		txd_vld_i = 1'b0; // Ends the packet
		txd_i     = '0;
		next_cycle();
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_LIMIT)
		begin
			next_cycle();
			waited++;
		end
		if (exp_q.size() != 0)
		begin
			fail_cnt++;
			$display("Timeout at %0t: %0d expected words never reached the line", $time,
				exp_q.size());
			aborted = 1'b1;
		end
	endtask

	initial
	begin
		int len;
		int pause;
		arst         = 1'b1;
		txd_vld_i    = 1'b0;
		txd_i        = '0;
		lcg_state    = 32'd54;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		aborted      = 1'b0;
		idle_run     = 0;
		word_idx     = 0;
		in_pkt       = 1'b0;
		seen_ext     = 1'b0;
		repeat (4) next_cycle();
		check_reset_state();
		arst = 1'b0;
		repeat (IPG_WORDS + 2) next_cycle();
		check_reset_state();

		// Short directed packet after a long idle gap
		pkt_data[0] = 16'h0201;
		pkt_data[1] = 16'h50BC; // Looks like idle but carries no K-flag
		pkt_data[2] = 16'hFBF7;
		send_packet(3, 1'b1);
		if (!aborted)
			wait_drained();

		for (int p = 0; p < N_RANDOM && !aborted; p++)
		begin
			lcg_state = lcg_next(lcg_state);
			len       = 1 + int'(lcg_state[30:16] % 40);
			pause     = lcg_state[31] ? 0 : int'(lcg_state[27:25]); // Zero means back to back
			fill_random(len);
			send_packet(len, 1'b0);
			repeat (pause) next_cycle();
		end
		if (!aborted)
			wait_drained();
		repeat (IPG_WORDS + 4) next_cycle(); // Stray words would show up here

		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	////////////////////
	// Line collector
	////////////////////

	always @(negedge usr_clk_wordwise)
	begin
		if (!arst)
		begin
			if (tx_data_o == 16'h50BC && tx_charisk_o == 2'b01)
			begin
				idle_run++;
				assert (!in_pkt)
				else
				begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: idle word inside a packet after word %0d", $time,
						word_idx);
				end
			end
			else
			begin
				assert (exp_q.size() != 0)
				else
				begin
					mismatch_cnt++;
					$display("MISMATCH at %0t: word %h/%b while no packet was pending", $time,
						tx_data_o, tx_charisk_o);
				end
				if (exp_q.size() != 0)
				begin
					exp_entry = exp_q.pop_front();
					assert ({tx_charisk_o, tx_data_o} == exp_entry)
					else
					begin
						mismatch_cnt++;
						$display("MISMATCH at %0t: word %0d is %h/%b, expected %h/%b", $time,
							word_idx, tx_data_o, tx_charisk_o,
							exp_entry[15:0], exp_entry[17:16]);
					end
					if (exp_entry == SOP_ENTRY)
					begin
						if (seen_ext)
						begin
							assert (idle_run >= IPG_WORDS)
							else
							begin
								mismatch_cnt++;
								$display("MISMATCH at %0t: only %0d idle words before SOP",
									$time, idle_run);
							end
						end
						in_pkt = 1'b1;
					end
					else if (exp_entry == EXT_ENTRY)
					begin
						exp_len = len_q.pop_front();
						assert (pkt_len_o == exp_len[9:0])
						else
						begin
							mismatch_cnt++;
							$display("MISMATCH at %0t: packet length %0d, expected %0d",
								$time, pkt_len_o, exp_len);
						end
						in_pkt   = 1'b0;
						seen_ext = 1'b1;
						idle_run = 0;
					end
					word_idx++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/daq_frame_tx.sv
`default_nettype none

module daq_frame_tx #(
	parameter int unsigned IPG_WORDS      = 4,
	parameter int unsigned PREAMBLE_WORDS = 2,
	parameter int unsigned PKT_LEN_RESET  = 800
)
(
	input  logic                     usr_clk_wordwise,
	input  logic                     arst,
	input  daq_line_pkg::line_word_t txd_i,
	input  logic                     txd_vld_i,
	output logic                     tx_ack_o,
	output daq_line_pkg::line_word_t tx_data_o,
	output daq_line_pkg::char_k_t    tx_charisk_o,
	output daq_frame_pkg::pkt_len_t  pkt_len_o
);

	import daq_frame_pkg::*;

	word_sel_t word_sel;
	logic      crc_init;
	logic      crc_calc;
	crc_t      fcs;

	frame_sequencer #(
		.IPG_WORDS      (IPG_WORDS),
		.PREAMBLE_WORDS (PREAMBLE_WORDS),
		.PKT_LEN_RESET  (PKT_LEN_RESET)
	)
	frame_sequencer_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.txd_vld_i        (txd_vld_i),
		.tx_ack_o         (tx_ack_o),
		.word_sel_o       (word_sel),
		.crc_init_o       (crc_init),
		.crc_calc_o       (crc_calc),
		.pkt_len_o        (pkt_len_o)
	);

	crc32_word crc32_word_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.init_i           (crc_init),
		.calc_i           (crc_calc),
		.data_i           (txd_i),
		.fcs_o            (fcs)
	);

	// Two register stages from select to line
	line_word_out line_word_out_i
	(
		.usr_clk_wordwise (usr_clk_wordwise),
		.arst             (arst),
		.word_sel_i       (word_sel),
		.data_i           (txd_i),
		.fcs_i            (fcs),
		.tx_data_o        (tx_data_o),
		.tx_charisk_o     (tx_charisk_o)
	);

endmodule : daq_frame_tx

`default_nettype wire

//--- source/line_word_out.sv
`default_nettype none

module line_word_out
(
	input  logic                     usr_clk_wordwise,
	input  logic                     arst,
	input  daq_frame_pkg::word_sel_t word_sel_i,
	input  daq_line_pkg::line_word_t data_i,
	input  daq_frame_pkg::crc_t      fcs_i,
	output daq_line_pkg::line_word_t tx_data_o,
	output daq_line_pkg::char_k_t    tx_charisk_o
);

	import daq_line_pkg::*;
	import daq_frame_pkg::*;

	word_sel_t  sel_q;
	line_word_t data_q;
	line_word_t word_d;
	char_k_t    k_d;

	////////////////////
	// Stage one
	////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			sel_q <= SEL_IDLE;
		else
			sel_q <= word_sel_i;
	end

	always_ff @(posedge usr_clk_wordwise)
	begin
		data_q <= data_i; // User word rides along with its select
	end

	////////////////////
	// Stage two
	////////////////////

	always_comb
	begin
		word_d = IDLE_WORD;
		k_d    = K_IDLE;
		unique case (sel_q)
			SEL_SOP:    begin word_d = SOP_WORD;     k_d = K_SOP;  end
			SEL_PRE:    begin word_d = PRE_WORD;     k_d = K_NONE; end
			SEL_SOF:    begin word_d = SOF_WORD;     k_d = K_NONE; end
			SEL_DATA:   begin word_d = data_q;       k_d = K_NONE; end
			SEL_FCS_LO: begin word_d = fcs_i[15:0];  k_d = K_NONE; end
			SEL_FCS_HI: begin word_d = fcs_i[31:16]; k_d = K_NONE; end
			SEL_EOP:    begin word_d = EOP_WORD;     k_d = K_EOP;  end
			SEL_EXT:    begin word_d = EXT_WORD;     k_d = K_EXT;  end
			default:    begin word_d = IDLE_WORD;    k_d = K_IDLE; end
		endcase
	end

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			tx_data_o    <= IDLE_WORD;
			tx_charisk_o <= K_IDLE;
		end
		else
		begin
			tx_data_o    <= word_d;
			tx_charisk_o <= k_d;
		end
	end

endmodule : line_word_out

`default_nettype wire

//--- source/crc32_word.sv
`default_nettype none

module crc32_word
(
	input  logic                     usr_clk_wordwise,
	input  logic                     arst,
	input  logic                     init_i,
	input  logic                     calc_i,
	input  daq_line_pkg::line_word_t data_i,
	output daq_frame_pkg::crc_t      fcs_o
);

	import daq_line_pkg::*;
	import daq_frame_pkg::*;

	crc_t crc_q;
	crc_t crc_next;

	// Sixteen serial steps of the reflected CRC.
	// Bit 0 of the word is the first bit on the line.
	function automatic crc_t crc_step16(input crc_t crc_in, input line_word_t d);
		crc_t c;
		logic fb;
		c = crc_in;
		for (int i = 0; i < 16; i++)
		begin
			fb = c[0] ^ d[i];
			c  = c >> 1;
			if (fb)
				c = c ^ CRC_POLY_REFL;
		end
		return c;
	endfunction

	assign crc_next = crc_step16(crc_q, data_i);

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
			crc_q <= CRC_PRESET;
		else if (init_i)
			crc_q <= CRC_PRESET;
		else if (calc_i)
			crc_q <= crc_next;
	end

	// Held until the next init, so the FCS words can be read late
	assign fcs_o = ~crc_q;

endmodule : crc32_word

`default_nettype wire

//--- source/frame_sequencer.sv
`default_nettype none

module frame_sequencer #(
	parameter int unsigned IPG_WORDS      = 4,
	parameter int unsigned PREAMBLE_WORDS = 2,
	parameter int unsigned PKT_LEN_RESET  = 800
)
(
	input  logic                     usr_clk_wordwise,
	input  logic                     arst,
	input  logic                     txd_vld_i,
	output logic                     tx_ack_o,
	output daq_frame_pkg::word_sel_t word_sel_o,
	output logic                     crc_init_o,
	output logic                     crc_calc_o,
	output daq_frame_pkg::pkt_len_t  pkt_len_o
);

	import daq_frame_pkg::*;

	localparam int GAP_W = (IPG_WORDS > 0) ? $clog2(IPG_WORDS + 1) : 1;
	localparam int PRE_W = (PREAMBLE_WORDS > 1) ? $clog2(PREAMBLE_WORDS) : 1;

	frame_state_t     state_q;
	frame_state_t     state_d;
	logic [GAP_W-1:0] gap_cnt;
	logic [PRE_W-1:0] pre_cnt;
	pkt_len_t         data_cnt;
	logic             gap_ok;
	logic             pre_last;

	// Current idle word counts toward the gap
	assign gap_ok   = (int'(gap_cnt) + 1 >= IPG_WORDS);
	assign pre_last = (int'(pre_cnt) + 1 >= PREAMBLE_WORDS);

	assign tx_ack_o   = (state_q == FS_SOF);
	assign crc_init_o = (state_q == FS_SOF);
	assign crc_calc_o = (state_q == FS_DATA) && txd_vld_i;

	////////////////////
	// Next state and word select
	////////////////////

	always_comb
	begin
		state_d    = state_q;
		word_sel_o = SEL_IDLE;
		unique case (state_q)
			FS_GAP:
			begin
				word_sel_o = SEL_IDLE;
				if (txd_vld_i && gap_ok)
					state_d = FS_SOP;
			end
			FS_SOP:
			begin
				word_sel_o = SEL_SOP;
				state_d    = (PREAMBLE_WORDS == 0) ? FS_SOF : FS_PRE;
			end
			FS_PRE:
			begin
				word_sel_o = SEL_PRE;
				if (pre_last)
					state_d = FS_SOF;
			end
			FS_SOF:
			begin
				word_sel_o = SEL_SOF;
				state_d    = FS_DATA;
			end
			FS_DATA:
			begin
				if (txd_vld_i)
					word_sel_o = SEL_DATA;
				else
				begin
					word_sel_o = SEL_FCS_LO; // Valid dropped so the FCS follows at once
					state_d    = FS_FCS_HI;
				end
			end
			FS_FCS_HI:
			begin
				word_sel_o = SEL_FCS_HI;
				state_d    = FS_EOP;
			end
			FS_EOP:
			begin
				word_sel_o = SEL_EOP;
				state_d    = FS_EXT;
			end
			FS_EXT:
			begin
				word_sel_o = SEL_EXT;
				state_d    = FS_GAP;
			end
			default: state_d = FS_GAP;
		endcase
	end

	////////////////////
	// State and counters
	////////////////////

	always_ff @(posedge usr_clk_wordwise or posedge arst)
	begin
		if (arst)
		begin
			state_q   <= FS_GAP;
			gap_cnt   <= '0;
			pre_cnt   <= '0;
			data_cnt  <= '0;
			pkt_len_o <= pkt_len_t'(PKT_LEN_RESET);
		end
		else
		begin
			state_q <= state_d;

			// Idle words since the last EXT, saturating
			if (state_q != FS_GAP)
				gap_cnt <= '0;
			else if (int'(gap_cnt) < IPG_WORDS)
				gap_cnt <= gap_cnt + 1'b1;

			if (state_q == FS_PRE && !pre_last)
				pre_cnt <= pre_cnt + 1'b1;
			else
				pre_cnt <= '0;

			if (state_q == FS_SOF)
				data_cnt <= '0;
			else if (crc_calc_o)
				data_cnt <= data_cnt + 1'b1;

			if (state_q == FS_DATA && !txd_vld_i)
				pkt_len_o <= data_cnt; // Length of the packet just closed
		end
	end

endmodule : frame_sequencer

`default_nettype wire

//--- source/daq_frame_pkg.sv
`default_nettype none

package daq_frame_pkg;

	// Packet states of the sequencer
	typedef enum logic [2:0]
	{
		FS_GAP,
		FS_SOP,
		FS_PRE,
		FS_SOF,
		FS_DATA,
		FS_FCS_HI,
		FS_EOP,
		FS_EXT
	} frame_state_t;

	// Word type chosen for one line slot
	typedef enum logic [3:0]
	{
		SEL_IDLE,
		SEL_SOP,
		SEL_PRE,
		SEL_SOF,
		SEL_DATA,
		SEL_FCS_LO,
		SEL_FCS_HI,
		SEL_EOP,
		SEL_EXT
	} word_sel_t;

	typedef logic [31:0] crc_t;
	typedef logic [9:0]  pkt_len_t; // Data words per packet

	localparam crc_t CRC_POLY_REFL = 32'hEDB8_8320; // Ethernet polynomial, bit reversed
	localparam crc_t CRC_PRESET    = 32'hFFFF_FFFF;

endpackage : daq_frame_pkg

`default_nettype wire

//--- source/daq_line_pkg.sv
`default_nettype none

package daq_line_pkg;

	typedef logic [15:0] line_word_t; // Low octet goes out first
	typedef logic [1:0]  char_k_t;    // Bit 0 flags the low octet
	typedef logic [7:0]  octet_t;

	////////////////////
	// 8b10b octets
	////////////////////

	localparam octet_t K28_5    = 8'hBC; // Comma
	localparam octet_t D16_2    = 8'h50;
	localparam octet_t K27_7    = 8'hFB; // /S/
	localparam octet_t K29_7    = 8'hFD; // /T/
	localparam octet_t K23_7    = 8'hF7; // /R/
	localparam octet_t PRMBL    = 8'h55;
	localparam octet_t SOF_BYTE = 8'hD5;

	////////////////////
	// Ordered-set words
	////////////////////

	localparam line_word_t IDLE_WORD = {D16_2, K28_5};
	localparam line_word_t SOP_WORD  = {PRMBL, K27_7};    // /S/ plus first preamble octet
	localparam line_word_t PRE_WORD  = {PRMBL, PRMBL};
	localparam line_word_t SOF_WORD  = {SOF_BYTE, PRMBL}; // Last preamble octet plus SFD
	localparam line_word_t EOP_WORD  = {K23_7, K29_7};    // /T/ then /R/
	localparam line_word_t EXT_WORD  = {K23_7, K23_7};    // Carrier extend

	// K-flag patterns that go with the words above
	localparam char_k_t K_IDLE = 2'b01;
	localparam char_k_t K_SOP  = 2'b01;
	localparam char_k_t K_NONE = 2'b00; // Preamble, SOF, data and FCS
	localparam char_k_t K_EOP  = 2'b11;
	localparam char_k_t K_EXT  = 2'b11;

endpackage : daq_line_pkg

`default_nettype wire
